// File: common/pwrPkg.sv
/* Shared widths, register map, sequencer timing and state encoding for the
   power shut-off controller. Referenced by scoped names from RTL and testbench */
`default_nettype none

package pwrPkg;

  // --------------------------------------------------
  // Widths
  // --------------------------------------------------
  localparam int NumDomains = 4;

  // One bit per switchable domain
  typedef logic [NumDomains-1:0] domainVecT;

  // Wishbone word address and data
  typedef logic [3:0]  wbAdrT;
  typedef logic [31:0] wbDataT;

  // --------------------------------------------------
  // Register map (word addresses)
  // --------------------------------------------------
  localparam wbAdrT AdrReq      = 4'd0;  // Request, read/write
  localparam wbAdrT AdrStatus   = 4'd1;  // In-sequence status, read-only
  localparam wbAdrT AdrWakeDone = 4'd2;  // Wake done, write one to clear
  localparam wbAdrT AdrIrqEn    = 4'd3;  // Interrupt enable, read/write

  // --------------------------------------------------
  // Sequencer timing and states
  // --------------------------------------------------
  // Cycles spent in the second power-on stage
  localparam int SettleCycles = 28;

  typedef logic [4:0] settleCntT;

  typedef enum logic [3:0] {
    Init, ClkOff, Wait1, Isolate, SaveEdge, PrePwrOff, PwrOff,
    PwrOn1, PwrOn2, RestoreEdge, Wait2, DeIsolate, ClkOn, Wait3, RstClr
  } pwrStateT;

endpackage

`default_nettype wire

// File: pwrSeq/pwrSeqFsm.sv
/* Power shut-off sequencer for one domain. Follows l1Req to power the domain
   down and back up, with every control line registered from the next state */
`timescale 1ns/1ps
`default_nettype none

module pwrSeqFsm (
  input  wire  pclk21,
  input  wire  nprst21,
  input  logic l1Req,
  output logic setStatus,
  output logic clrStatus,
  output logic gateClk,
  output logic isolate,
  output logic saveEdge,
  output logic restoreEdge,
  output logic pwr1On,
  output logic pwr2On,
  output logic rstnNonSrpg
);

  pwrPkg::pwrStateT  state;
  pwrPkg::pwrStateT  nextState;
  pwrPkg::settleCntT settleCnt;

  // Non-retention reset before it is combined with the chip reset
  logic rstnNonSrpgReg;

  // --------------------------------------------------
  // Next-state logic
  // --------------------------------------------------
  always_comb
  begin
    nextState = state;
    case (state)
      // Wait here until a low-power request arrives
      pwrPkg::Init:
        if (l1Req)
          nextState = pwrPkg::ClkOff;
      pwrPkg::ClkOff:      nextState = pwrPkg::Wait1;
      // One spare cycle for the clock gate to settle
      pwrPkg::Wait1:       nextState = pwrPkg::Isolate;
      pwrPkg::Isolate:     nextState = pwrPkg::SaveEdge;
      pwrPkg::SaveEdge:    nextState = pwrPkg::PrePwrOff;
      pwrPkg::PrePwrOff:   nextState = pwrPkg::PwrOff;
      // Stay powered off until the request is released
      pwrPkg::PwrOff:
        if (!l1Req)
          nextState = pwrPkg::PwrOn1;
      pwrPkg::PwrOn1:      nextState = pwrPkg::PwrOn2;
      // Hold for the settle count before restoring state
      pwrPkg::PwrOn2:
        if (settleCnt == '0)
          nextState = pwrPkg::RestoreEdge;
      pwrPkg::RestoreEdge: nextState = pwrPkg::Wait2;
      pwrPkg::Wait2:       nextState = pwrPkg::DeIsolate;
      pwrPkg::DeIsolate:   nextState = pwrPkg::ClkOn;
      // Give the ungated clock a cycle before releasing reset
      pwrPkg::ClkOn:       nextState = pwrPkg::Wait3;
      pwrPkg::Wait3:       nextState = pwrPkg::RstClr;
      pwrPkg::RstClr:      nextState = pwrPkg::Init;
      default:             nextState = pwrPkg::Init;
    endcase
  end

  always_ff @(posedge pclk21 or negedge nprst21)
  begin
    if (!nprst21)
      state <= pwrPkg::Init;
    else
      state <= nextState;
  end

  // --------------------------------------------------
  // Settle counter for PwrOn2
  // --------------------------------------------------
  // Loaded on entry so that PwrOn2 lasts exactly SettleCycles cycles
  always_ff @(posedge pclk21 or negedge nprst21)
  begin
    if (!nprst21)
      settleCnt <= '0;
    else if (nextState == pwrPkg::PwrOn2 && state != pwrPkg::PwrOn2)
      settleCnt <= pwrPkg::settleCntT'(pwrPkg::SettleCycles - 1);
    else if (state == pwrPkg::PwrOn2 && settleCnt != '0)
      settleCnt <= settleCnt - 1'b1;
  end

  // --------------------------------------------------
  // Registered control outputs
  // --------------------------------------------------
  always_ff @(posedge pclk21 or negedge nprst21)
  begin
    if (!nprst21)
    begin
      gateClk        <= 1'b0;
      isolate        <= 1'b0;
      saveEdge       <= 1'b0;
      restoreEdge    <= 1'b0;
      pwr1On         <= 1'b1;
      pwr2On         <= 1'b1;
      rstnNonSrpgReg <= 1'b1;
    end
    else
    begin
      // Clock stays gated from ClkOff up to DeIsolate
      gateClk <= !(nextState == pwrPkg::Init || nextState == pwrPkg::ClkOn ||
                   nextState == pwrPkg::Wait3 || nextState == pwrPkg::RstClr);

      // Isolation covers the whole unpowered window plus margins
      isolate <= (nextState == pwrPkg::Isolate     || nextState == pwrPkg::SaveEdge ||
                  nextState == pwrPkg::PrePwrOff   || nextState == pwrPkg::PwrOff   ||
                  nextState == pwrPkg::PwrOn1      || nextState == pwrPkg::PwrOn2   ||
                  nextState == pwrPkg::RestoreEdge || nextState == pwrPkg::Wait2);

      // Single-cycle retention strobes
      saveEdge    <= (nextState == pwrPkg::SaveEdge);
      restoreEdge <= (nextState == pwrPkg::RestoreEdge);

      // Power returns in two stages, switch 1 one cycle ahead of switch 2
      pwr1On <= (nextState != pwrPkg::PwrOff);
      pwr2On <= !(nextState == pwrPkg::PwrOff || nextState == pwrPkg::PwrOn1);

      // Non-retention flops held in reset from PwrOff until RstClr
      rstnNonSrpgReg <= (nextState == pwrPkg::Init      || nextState == pwrPkg::ClkOff ||
                         nextState == pwrPkg::Wait1     || nextState == pwrPkg::Isolate ||
                         nextState == pwrPkg::SaveEdge  || nextState == pwrPkg::PrePwrOff ||
                         nextState == pwrPkg::RstClr);
    end
  end

  // Chip reset also forces the non-retention reset
  assign rstnNonSrpg = rstnNonSrpgReg & nprst21;

  // Status pulses to the register block
  assign setStatus = (nextState == pwrPkg::ClkOff);
  assign clrStatus = (state == pwrPkg::RstClr);

endmodule

`default_nettype wire

// File: logic/pwrRegs.sv
/* Wishbone classic register block with request, status, wake-done and
   interrupt-enable words. Drives the per-domain requests and the interrupt */
`timescale 1ns/1ps
`default_nettype none

module pwrRegs (
  input  wire                pclk21,
  input  wire                nprst21,
  input  logic               wbCyc,
  input  logic               wbStb,
  input  logic               wbWe,
  input  pwrPkg::wbAdrT      wbAdr,
  input  pwrPkg::wbDataT     wbDatW,
  output pwrPkg::wbDataT     wbDatR,
  output logic               wbAck,
  input  pwrPkg::domainVecT  setStatus,
  input  pwrPkg::domainVecT  clrStatus,
  output pwrPkg::domainVecT  l1Req,
  output logic               irq
);

  pwrPkg::domainVecT irqEn;
  pwrPkg::domainVecT status;
  pwrPkg::domainVecT wakeDone;
  pwrPkg::domainVecT wakeClr;

  logic access;
  logic wrEn;

  // --------------------------------------------------
  // Bus handshake
  // --------------------------------------------------
  // New access only while ack is low, so ack lasts one cycle
  assign access = wbCyc & wbStb & ~wbAck;
  assign wrEn   = access & wbWe;

  always_ff @(posedge pclk21 or negedge nprst21)
  begin
    if (!nprst21)
      wbAck <= 1'b0;
    else
      wbAck <= access;
  end

  // --------------------------------------------------
  // Writable words
  // --------------------------------------------------
  always_ff @(posedge pclk21 or negedge nprst21)
  begin
    if (!nprst21)
    begin
      l1Req <= '0;
      irqEn <= '0;
    end
    else if (wrEn)
    begin
      if (wbAdr == pwrPkg::AdrReq)
        l1Req <= wbDatW[pwrPkg::NumDomains-1:0];
      if (wbAdr == pwrPkg::AdrIrqEn)
        irqEn <= wbDatW[pwrPkg::NumDomains-1:0];
    end
  end

  // Write-one-to-clear mask for wake-done
  assign wakeClr = (wrEn && wbAdr == pwrPkg::AdrWakeDone) ?
                   wbDatW[pwrPkg::NumDomains-1:0] : '0;

  // Status follows the sequencer pulses; wake-done set beats a clearing write
  always_ff @(posedge pclk21 or negedge nprst21)
  begin
    if (!nprst21)
    begin
      status   <= '0;
      wakeDone <= '0;
    end
    else
    begin
      status   <= (status | setStatus) & ~(clrStatus & ~setStatus);
      wakeDone <= (wakeDone & ~wakeClr) | clrStatus;
    end
  end

  // --------------------------------------------------
  // Read path
  // --------------------------------------------------
  always_ff @(posedge pclk21 or negedge nprst21)
  begin
    if (!nprst21)
      wbDatR <= '0;
    else if (access && !wbWe)
    begin
      case (wbAdr)
        pwrPkg::AdrReq:      wbDatR <= pwrPkg::wbDataT'(l1Req);
        pwrPkg::AdrStatus:   wbDatR <= pwrPkg::wbDataT'(status);
        pwrPkg::AdrWakeDone: wbDatR <= pwrPkg::wbDataT'(wakeDone);
        pwrPkg::AdrIrqEn:    wbDatR <= pwrPkg::wbDataT'(irqEn);
        // Unmapped words
        default:             wbDatR <= '0;
      endcase
    end
  end

  // Any enabled wake-done raises the line
  assign irq = |(wakeDone & irqEn);

endmodule

`default_nettype wire

// File: logic/pwrCtrlTop.sv
/* Power controller top. Joins the Wishbone register block to one shut-off
   sequencer per domain */
`timescale 1ns/1ps
`default_nettype none

module pwrCtrlTop (
  input  wire                pclk21,
  input  wire                nprst21,
  input  logic               wbCyc,
  input  logic               wbStb,
  input  logic               wbWe,
  input  pwrPkg::wbAdrT      wbAdr,
  input  pwrPkg::wbDataT     wbDatW,
  output pwrPkg::wbDataT     wbDatR,
  output logic               wbAck,
  output logic               irq,
  output pwrPkg::domainVecT  gateClk,
  output pwrPkg::domainVecT  isolate,
  output pwrPkg::domainVecT  saveEdge,
  output pwrPkg::domainVecT  restoreEdge,
  output pwrPkg::domainVecT  pwr1On,
  output pwrPkg::domainVecT  pwr2On,
  output pwrPkg::domainVecT  rstnNonSrpg
);

  // Request out, status pulses back
  pwrPkg::domainVecT l1Req;
  pwrPkg::domainVecT setStatus;
  pwrPkg::domainVecT clrStatus;

  pwrRegs uRegs (
    .pclk21    (pclk21),
    .nprst21   (nprst21),
    .wbCyc     (wbCyc),
    .wbStb     (wbStb),
    .wbWe      (wbWe),
    .wbAdr     (wbAdr),
    .wbDatW    (wbDatW),
    .wbDatR    (wbDatR),
    .wbAck     (wbAck),
    .setStatus (setStatus),
    .clrStatus (clrStatus),
    .l1Req     (l1Req),
    .irq       (irq)
  );

  // --------------------------------------------------
  // One sequencer per domain
  // --------------------------------------------------
  for (genvar dom = 0; dom < pwrPkg::NumDomains; dom++)
  begin : genDomain
    pwrSeqFsm uSeq (
      .pclk21      (pclk21),
      .nprst21     (nprst21),
      .l1Req       (l1Req[dom]),
      .setStatus   (setStatus[dom]),
      .clrStatus   (clrStatus[dom]),
      .gateClk     (gateClk[dom]),
      .isolate     (isolate[dom]),
      .saveEdge    (saveEdge[dom]),
      .restoreEdge (restoreEdge[dom]),
      .pwr1On      (pwr1On[dom]),
      .pwr2On      (pwr2On[dom]),
      .rstnNonSrpg (rstnNonSrpg[dom])
    );
  end

endmodule

`default_nettype wire

// File: sim/pwrSeqModel.svh
/* Reference model of one domain's sequencer outputs, counted in clock edges
   after the request and release write edges. Included by the testbench */
`ifndef PWR_SEQ_MODEL_SVH
`define PWR_SEQ_MODEL_SVH

// Output bits {gateClk, isolate, saveEdge, restoreEdge, pwr1On, pwr2On, rstnNonSrpg}

// Power-up edge counted from the request write edge
function automatic int powerUpEdge(input int sinceReq, input int sinceRel);
  int fromWrite;
  fromWrite = sinceReq - sinceRel + 1;
  // Release is seen only in PwrOff and first sampled one edge after entering it
  return (fromWrite > 7) ? fromWrite : 7;
endfunction

// True once the domain is back in Init or was never requested
function automatic logic sequenceDone(input int sinceReq, input int sinceRel);
  if (sinceReq < 0)
    return 1'b1;
  if (sinceRel < 0)
    return 1'b0;
  // Init is reached six edges after restoreEdge
  return (sinceReq - powerUpEdge(sinceReq, sinceRel)) >= pwrPkg::SettleCycles + 7;
endfunction

function automatic logic [6:0] expectOutputs(input int sinceReq, input int sinceRel);
  int k;
  int j;
  logic [6:0] o;
  // Idle with power switches on and non-retention reset released
  o = 7'b0000111;
  if (sinceReq < 0)
    return o;
  j = (sinceRel < 0) ? -1 : sinceReq - powerUpEdge(sinceReq, sinceRel);
  if (j < 0)
  begin
    // Power-down with k counted from E0
    k = sinceReq - 1;
    o[6] = (k >= 0);
    o[5] = (k >= 2);
    o[4] = (k == 3);
    if (k >= 5)
      o[2:0] = 3'b000;
  end
  else if (j <= pwrPkg::SettleCycles + 5)
  begin
    // Power-up with j counted from E1 and restoreEdge on SettleCycles + 1
    o[6] = (j <= pwrPkg::SettleCycles + 3);
    o[5] = (j <= pwrPkg::SettleCycles + 2);
    o[3] = (j == pwrPkg::SettleCycles + 1);
    o[2] = 1'b1;
    // Second switch one edge behind the first
    o[1] = (j >= 1);
    o[0] = 1'b0;
  end
  return o;
endfunction

`endif

// File: sim/pwrCtrlTb.sv
/* Testbench for the power controller top. Runs directed and random request
   sequences over Wishbone and checks every domain against the reference model */
`timescale 1ns/1ps
`default_nettype none

module pwrCtrlTb;

  localparam int ClkPeriod  = 4;
  localparam int WatchdogNs =
    pwrPkg::NumDomains * (pwrPkg::SettleCycles + 60) * ClkPeriod + 2000;

  logic              pclk21;
  logic              nprst21;
  logic              wbCyc;
  logic              wbStb;
  logic              wbWe;
  pwrPkg::wbAdrT     wbAdr;
  pwrPkg::wbDataT    wbDatW;
  pwrPkg::wbDataT    wbDatR;
  logic              wbAck;
  logic              irq;
  pwrPkg::domainVecT gateClk;
  pwrPkg::domainVecT isolate;
  pwrPkg::domainVecT saveEdge;
  pwrPkg::domainVecT restoreEdge;
  pwrPkg::domainVecT pwr1On;
  pwrPkg::domainVecT pwr2On;
  pwrPkg::domainVecT rstnNonSrpg;

  // Edges since the last request and release write (-1 when none)
  int sinceReq [pwrPkg::NumDomains];
  int sinceRel [pwrPkg::NumDomains];

  // Expected register contents
  pwrPkg::domainVecT reqShadow;
  pwrPkg::domainVecT irqEnShadow;
  pwrPkg::domainVecT statusExp;
  pwrPkg::domainVecT wakeExp;
  pwrPkg::domainVecT doneShadow;
  logic              ackPrev;

  `include "pwrSeqModel.svh"

  pwrCtrlTop dut (.*);

  always #(ClkPeriod / 2) pclk21 = ~pclk21;

  task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
    if (actual !== expected)
    begin
      $display("Fail at %0d ns: %s, got 0x%0h, expected 0x%0h", $time, what, actual,
               expected);
      $display("Done: errors found");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  // --------------------------------------------------
  // Wishbone master
  // --------------------------------------------------
  task automatic wbWrite(input pwrPkg::wbAdrT adr, input pwrPkg::wbDataT data);
    @(negedge pclk21);
    wbCyc  = 1'b1;
    wbStb  = 1'b1;
    wbWe   = 1'b1;
    wbAdr  = adr;
    wbDatW = data;
    @(negedge pclk21);
    while (!wbAck)
      @(negedge pclk21);
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe  = 1'b0;
  endtask

  task automatic wbRead(input pwrPkg::wbAdrT adr, output pwrPkg::wbDataT data);
    @(negedge pclk21);
    wbCyc = 1'b1;
    wbStb = 1'b1;
    wbWe  = 1'b0;
    wbAdr = adr;
    @(negedge pclk21);
    while (!wbAck)
      @(negedge pclk21);
    // Read data valid while ack is high
    data  = wbDatR;
    wbCyc = 1'b0;
    wbStb = 1'b0;
  endtask

  // Block until the model has every domain back in Init
  task automatic waitAllDone();
    int d;
    logic busy;
    busy = 1'b1;
    while (busy)
    begin
      @(negedge pclk21);
      busy = 1'b0;
      for (d = 0; d < pwrPkg::NumDomains; d++)
        if (!sequenceDone(sinceReq[d], sinceRel[d]))
          busy = 1'b1;
    end
  endtask

  // --------------------------------------------------
  // Compare one step after each rising edge
  // --------------------------------------------------
  always @(posedge pclk21)
  begin
    int d;
    logic doneNow;
    pwrPkg::wbDataT readExp;
    #1;
    if (!nprst21)
    begin
      // Reset values with the non-retention reset forced low
      for (d = 0; d < pwrPkg::NumDomains; d++)
        checkValue({gateClk[d], isolate[d], saveEdge[d], restoreEdge[d], pwr1On[d],
                    pwr2On[d], rstnNonSrpg[d]}, 7'b0000110, "reset outputs");
      checkValue(irq, 1'b0, "irq in reset");
      checkValue(wbAck, 1'b0, "ack in reset");
    end
    else
    begin
      checkValue(wbAck & ackPrev, 1'b0, "ack held over two cycles");
      // Read data reflects the registers before this edge
      if (wbAck && !wbWe)
      begin
        case (wbAdr)
          pwrPkg::AdrReq:      readExp = pwrPkg::wbDataT'(reqShadow);
          pwrPkg::AdrStatus:   readExp = pwrPkg::wbDataT'(statusExp);
          pwrPkg::AdrWakeDone: readExp = pwrPkg::wbDataT'(wakeExp);
          pwrPkg::AdrIrqEn:    readExp = pwrPkg::wbDataT'(irqEnShadow);
          default:             readExp = '0;
        endcase
        checkValue(wbDatR, readExp, $sformatf("read of word %0d", wbAdr));
      end
      for (d = 0; d < pwrPkg::NumDomains; d++)
      begin
        if (sinceReq[d] >= 0)
          sinceReq[d]++;
        if (sinceRel[d] >= 0)
          sinceRel[d]++;
      end
      // Writes take effect at the edge that raises ack
      if (wbAck && wbWe)
      begin
        if (wbAdr == pwrPkg::AdrReq)
        begin
          for (d = 0; d < pwrPkg::NumDomains; d++)
          begin
            if (wbDatW[d] && !reqShadow[d])
            begin
              sinceReq[d] = 0;
              sinceRel[d] = -1;
            end
            else if (!wbDatW[d] && reqShadow[d])
              sinceRel[d] = 0;
          end
          reqShadow = wbDatW[pwrPkg::NumDomains-1:0];
        end
        if (wbAdr == pwrPkg::AdrIrqEn)
          irqEnShadow = wbDatW[pwrPkg::NumDomains-1:0];
        if (wbAdr == pwrPkg::AdrWakeDone)
          wakeExp = wakeExp & ~wbDatW[pwrPkg::NumDomains-1:0];
      end
      for (d = 0; d < pwrPkg::NumDomains; d++)
      begin
        doneNow = sequenceDone(sinceReq[d], sinceRel[d]);
        // Completion sets wake-done after any clear in the same cycle
        if (doneNow && !doneShadow[d])
          wakeExp[d] = 1'b1;
        doneShadow[d] = doneNow;
        statusExp[d]  = !doneNow && sinceReq[d] >= 1;
        checkValue({gateClk[d], isolate[d], saveEdge[d], restoreEdge[d], pwr1On[d],
                    pwr2On[d], rstnNonSrpg[d]}, expectOutputs(sinceReq[d], sinceRel[d]),
                   $sformatf("domain %0d outputs", d));
      end
      checkValue(irq, |(wakeExp & irqEnShadow), "irq");
    end
    ackPrev = wbAck;
  end

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  initial
  begin
    int i;
    int d;
    pwrPkg::domainVecT nextReq;
    pwrPkg::wbDataT rd;
    void'($urandom(71));
    pclk21      = 1'b0;
    nprst21     = 1'b0;
    wbCyc       = 1'b0;
    wbStb       = 1'b0;
    wbWe        = 1'b0;
    wbAdr       = '0;
    wbDatW      = '0;
    reqShadow   = '0;
    irqEnShadow = '0;
    statusExp   = '0;
    wakeExp     = '0;
    doneShadow  = '1;
    ackPrev     = 1'b0;
    for (d = 0; d < pwrPkg::NumDomains; d++)
    begin
      sinceReq[d] = -1;
      sinceRel[d] = -1;
    end
    repeat (16) @(posedge pclk21);
    @(negedge pclk21);
    nprst21 = 1'b1;

    // All words and one unmapped word read zero
    for (i = 0; i < 5; i++)
      wbRead(pwrPkg::wbAdrT'(i), rd);

    // Readback, masking of upper bits, read-only and unmapped words
    wbWrite(pwrPkg::AdrIrqEn, 32'hFFFF_FFF5);
    wbRead(pwrPkg::AdrIrqEn, rd);
    wbWrite(pwrPkg::AdrReq, 32'hFFFF_FFF0);
    wbRead(pwrPkg::AdrReq, rd);
    wbWrite(pwrPkg::wbAdrT'(9), 32'h1234_5678);
    wbRead(pwrPkg::wbAdrT'(9), rd);
    wbWrite(pwrPkg::AdrStatus, 32'hFFFF_FFFF);
    wbRead(pwrPkg::AdrStatus, rd);
    wbWrite(pwrPkg::AdrIrqEn, 32'h1);

    // Domain 0 down to PwrOff
    wbWrite(pwrPkg::AdrReq, 32'h1);
    wbRead(pwrPkg::AdrReq, rd);
    while (pwr1On[0])
      @(negedge pclk21);
    wbRead(pwrPkg::AdrStatus, rd);
    checkValue(rd, 32'h1, "status in PwrOff");

    // Domain 0 back up and wake-done raises irq
    wbWrite(pwrPkg::AdrReq, 32'h0);
    waitAllDone();
    wbRead(pwrPkg::AdrStatus, rd);
    checkValue(rd, 32'h0, "status after power-up");
    wbRead(pwrPkg::AdrWakeDone, rd);
    checkValue(rd, 32'h1, "wake-done after power-up");
    checkValue(irq, 1'b1, "irq after wake");
    wbWrite(pwrPkg::AdrWakeDone, 32'h1);
    checkValue(irq, 1'b0, "irq after clear");
    wbRead(pwrPkg::AdrWakeDone, rd);

    // Random requests with domains sequencing independently
    wbWrite(pwrPkg::AdrIrqEn, 32'hF);
    for (i = 0; i < 16; i++)
    begin
      repeat ($urandom_range(0, 7)) @(negedge pclk21);
      nextReq = reqShadow;
      for (d = 0; d < pwrPkg::NumDomains; d++)
      begin
        // Raise only from Init and release at any point
        if (!reqShadow[d] && sequenceDone(sinceReq[d], sinceRel[d]) && $urandom_range(0, 1))
          nextReq[d] = 1'b1;
        else if (reqShadow[d] && $urandom_range(0, 1))
          nextReq[d] = 1'b0;
      end
      wbWrite(pwrPkg::AdrReq, pwrPkg::wbDataT'(nextReq));
      if ($urandom_range(0, 3) == 0)
        wbRead(pwrPkg::AdrStatus, rd);
    end
    wbWrite(pwrPkg::AdrReq, 32'h0);
    waitAllDone();
    wbRead(pwrPkg::AdrWakeDone, rd);
    wbWrite(pwrPkg::AdrWakeDone, 32'hFFFF_FFFF);
    wbRead(pwrPkg::AdrWakeDone, rd);
    wbRead(pwrPkg::AdrStatus, rd);

    $display("Done: no errors");
    $finish;
  end

  // Watchdog sized from the number of domains and the settle time
  initial
  begin
    #(WatchdogNs);
    $display("Timeout: the run did not finish within %0d ns", WatchdogNs);
    $display("Done: errors found");
    $fatal(1, "Watchdog expired");
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+sim
common/pwrPkg.sv
pwrSeq/pwrSeqFsm.sv
logic/pwrRegs.sv
logic/pwrCtrlTop.sv
sim/pwrCtrlTb.sv

// File: Bender.yml
package:
  name: pwr_ctrl

sources:
  # Shared package
  - common/pwrPkg.sv
  # RTL
  - pwrSeq/pwrSeqFsm.sv
  - logic/pwrRegs.sv
  - logic/pwrCtrlTop.sv
  # Testbench
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/pwrCtrlTb.sv
